// ==== common/datapath_pkg.sv ====
package datapath_pkg;

    // widths and depths
    localparam int xlen       = 64;  // register and memory word
    localparam int ilen       = 32;  // instruction word
    localparam int rom_depth  = 16;
    localparam int dmem_depth = 16;
    localparam int reg_count  = 32;

    // address bits for the small memories
    localparam int rom_aw  = $clog2(rom_depth);
    localparam int dmem_aw = $clog2(dmem_depth);

    typedef logic [xlen-1:0] data_word_t;
    typedef logic [4:0]      reg_index_t;
    typedef logic [31:0]     pc_t;      // word address

    // operand select from the outside controller
    typedef logic [1:0] op_mem_t;
    localparam op_mem_t op_reg = 2'd0;  // alu b from rb
    localparam op_mem_t op_mem = 2'd1;  // load/store at base plus offset
    localparam op_mem_t op_imm = 2'd2;  // alu b from offset

    // r form, also covers the i form (imm sits over funct7/rs2)
    typedef struct packed {
        logic [6:0] funct7;
        reg_index_t rs2;
        reg_index_t rs1;
        logic [2:0] funct3;
        reg_index_t rd;
        logic [6:0] opcode;
    } r_fields_t;

    // s form, offset split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_index_t rs2;
        reg_index_t rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    typedef union packed {
        r_fields_t r;
        s_fields_t s;
    } instr_u;

    localparam logic [6:0] opcode_store = 7'b0100011;  // sd

    // test program, rv64 encodings
    localparam logic [ilen-1:0] program_rom [rom_depth] = '{
        0:       32'h00103083,  // ld   x1, 1(x0)
        1:       32'h00203103,  // ld   x2, 2(x0)
        2:       32'h002081b3,  // add  x3, x1, x2
        3:       32'h40118233,  // sub  x4, x3, x1
        4:       32'h003031a3,  // sd   x3, 3(x0)
        5:       32'h00403223,  // sd   x4, 4(x0)
        6:       32'h00a20493,  // addi x9, x4, 10
        7:       32'h00903423,  // sd   x9, 8(x0)
        default: '0
    };

    // data memory contents after reset
    localparam data_word_t dmem_init [dmem_depth] = '{
        1:       64'd10,
        2:       64'd20,
        default: '0
    };

endpackage

// ==== common/decode_if.sv ====
interface decode_if;

    datapath_pkg::instr_u     instruction;  // raw fetched word
    datapath_pkg::reg_index_t ra;           // rs1
    datapath_pkg::reg_index_t rb;           // rs2
    datapath_pkg::reg_index_t rw;           // rd
    datapath_pkg::data_word_t offset;       // sign extended i or s imm

    // fetch produces every field
    modport fetch (
        output instruction,
        output ra,
        output rb,
        output rw,
        output offset
    );

    // register bank only needs the indices
    modport bank (
        input ra,
        input rb,
        input rw
    );

    // execute takes the offset for alu b and the address
    modport exec (
        input offset
    );

endinterface

// ==== hw/instruction_fetch/instruction_fetch.sv ====
module instruction_fetch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pc_load,  // load strobe from controller
    input  datapath_pkg::pc_t pc_add,   // new pc value
    decode_if.fetch           dec
);

    localparam int imm_w = 12;
    localparam int ext_w = datapath_pkg::xlen - imm_w;

    datapath_pkg::pc_t    pc;
    datapath_pkg::instr_u word;

    logic [imm_w-1:0] imm_i;     // i form immediate
    logic [imm_w-1:0] imm_s;     // s form immediate
    logic [imm_w-1:0] imm_sel;
    logic             is_store;

    // program counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= pc_add;  // absolute load, no increment
        end
    end

    // rom read, pc wraps on the rom depth
    assign word = datapath_pkg::instr_u'(
        datapath_pkg::program_rom[pc[datapath_pkg::rom_aw-1:0]]);

    // i imm is the top 12 bits of the word
    assign imm_i = {word.r.funct7, word.r.rs2};

    // s imm is split, hi part on top, lo part where rd would sit
    assign imm_s = {word.s.imm_hi, word.s.imm_lo};

    // only the store opcode uses the split form
    assign is_store = (word.s.opcode == datapath_pkg::opcode_store);
    assign imm_sel  = is_store ? imm_s : imm_i;

    // decoded fields out on the interface
    always_comb begin
        dec.instruction = word;
        dec.ra          = word.r.rs1;
        dec.rb          = word.r.rs2;
        dec.rw          = word.r.rd;                          // meaningless for sd
        dec.offset      = {{ext_w{imm_sel[imm_w-1]}}, imm_sel};  // sign extend
    end

endmodule

// ==== hw/register_bank.sv ====
module register_bank (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     we_reg,   // write strobe
    input  datapath_pkg::data_word_t wb_data,  // write back value
    decode_if.bank                   dec,
    output datapath_pkg::data_word_t dout_a,   // read at ra
    output datapath_pkg::data_word_t dout_b    // read at rb
);

    datapath_pkg::data_word_t regs [datapath_pkg::reg_count];

    logic wr_en;

    // x0 is hardwired, never written
    assign wr_en = we_reg && (dec.rw != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < datapath_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[dec.rw] <= wb_data;  // lands at this edge
        end
    end

    // combinational reads, x0 forced to zero
    always_comb begin
        dout_a = regs[dec.ra];
        dout_b = regs[dec.rb];
        if (dec.ra == '0) begin
            dout_a = '0;
        end
        if (dec.rb == '0) begin
            dout_b = '0;
        end
    end

endmodule

// ==== hw/execute/execute_stage.sv ====
module execute_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  datapath_pkg::op_mem_t    op_mem_i,  // operand select
    input  logic                     add_sub,   // 1 = subtract
    input  logic                     we_mem,    // store strobe
    input  datapath_pkg::data_word_t dout_a,    // base / alu a
    input  datapath_pkg::data_word_t dout_b,    // alu b or store data
    decode_if.exec                   dec,
    output datapath_pkg::data_word_t dout_mem,  // memory read data
    output datapath_pkg::data_word_t wb_data    // to register bank
);

    datapath_pkg::data_word_t dmem [datapath_pkg::dmem_depth];

    datapath_pkg::data_word_t alu_b;
    datapath_pkg::data_word_t alu_res;
    datapath_pkg::data_word_t ea;         // effective address, full width
    logic [datapath_pkg::dmem_aw-1:0] addr;

    // operand b mux
    // both op_mem and op_imm take the offset
    assign alu_b = (op_mem_i == datapath_pkg::op_reg) ? dout_b : dec.offset;

    // add/sub alu
    always_comb begin
        if (add_sub) begin
            alu_res = dout_a - alu_b;
        end else begin
            alu_res = dout_a + alu_b;
        end
    end

    // address is always base plus offset, independent of add_sub
    assign ea   = dout_a + dec.offset;
    assign addr = ea[datapath_pkg::dmem_aw-1:0];  // wraps on 16 words

    // data memory, reset restores the initial image
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem <= datapath_pkg::dmem_init;
        end else if (we_mem) begin
            dmem[addr] <= dout_b;  // store data is rs2
        end
    end

    assign dout_mem = dmem[addr];  // async read

    // write back select
    always_comb begin
        if (op_mem_i == datapath_pkg::op_mem) begin
            wb_data = dout_mem;  // load
        end else begin
            wb_data = alu_res;   // reg or imm op
        end
    end

endmodule

// ==== hw/datapath_top.sv ====
module datapath_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pc_load,
    input  datapath_pkg::pc_t        pc_add,
    input  datapath_pkg::op_mem_t    op_mem_i,
    input  logic                     add_sub,
    input  logic                     we_reg,
    input  logic                     we_mem,
    output datapath_pkg::instr_u     instruction,
    output datapath_pkg::reg_index_t ra,
    output datapath_pkg::reg_index_t rb,
    output datapath_pkg::reg_index_t rw,
    output datapath_pkg::data_word_t offset,
    output datapath_pkg::data_word_t dout_a,
    output datapath_pkg::data_word_t dout_b,
    output datapath_pkg::data_word_t dout_mem
);

    datapath_pkg::data_word_t wb_data;  // execute back to the bank

    decode_if dec ();

    // fetch and decode
    instruction_fetch instruction_fetch_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc_load (pc_load),
        .pc_add  (pc_add),
        .dec     (dec.fetch)
    );

    // register file
    register_bank register_bank_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .we_reg  (we_reg),
        .wb_data (wb_data),
        .dec     (dec.bank),
        .dout_a  (dout_a),
        .dout_b  (dout_b)
    );

    // alu, data memory, write back
    execute_stage execute_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_mem_i (op_mem_i),
        .add_sub  (add_sub),
        .we_mem   (we_mem),
        .dout_a   (dout_a),
        .dout_b   (dout_b),
        .dec      (dec.exec),
        .dout_mem (dout_mem),
        .wb_data  (wb_data)
    );

    // decoded fields exposed for the testbench
    assign instruction = dec.instruction;
    assign ra          = dec.ra;
    assign rb          = dec.rb;
    assign rw          = dec.rw;
    assign offset      = dec.offset;

endmodule

// ==== verif/clock_gen.sv ====
module clock_gen (
    output logic clk,
    output logic rst_n
);

    // free running clock, period 20
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // reset held low for the first 5 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;  // released on the 5th edge
    end

endmodule

// ==== verif/datapath_tb.sv ====
module datapath_tb;

    logic                     clk;
    logic                     rst_n;
    logic                     pc_load;
    datapath_pkg::pc_t        pc_add;
    datapath_pkg::op_mem_t    op_mem_i;
    logic                     add_sub;
    logic                     we_reg;
    logic                     we_mem;
    datapath_pkg::instr_u     instruction;
    datapath_pkg::reg_index_t ra;
    datapath_pkg::reg_index_t rb;
    datapath_pkg::reg_index_t rw;
    datapath_pkg::data_word_t offset;
    datapath_pkg::data_word_t dout_a;
    datapath_pkg::data_word_t dout_b;
    datapath_pkg::data_word_t dout_mem;

    // one table row, controls first then expected outputs
    typedef struct packed {
        datapath_pkg::pc_t        pc;
        datapath_pkg::op_mem_t    op;
        logic                     sub;
        logic                     wr_reg;
        logic                     wr_mem;
        datapath_pkg::instr_u     instr;
        datapath_pkg::reg_index_t ra;
        datapath_pkg::reg_index_t rb;
        datapath_pkg::reg_index_t rw;
        datapath_pkg::data_word_t offset;
        datapath_pkg::data_word_t dout_a;
        datapath_pkg::data_word_t dout_b;
        datapath_pkg::data_word_t dout_mem;
    } row_t;

    row_t rows [$];
    int   row_errs;    // mismatches in the current test
    int   pass_count;
    int   fail_count;
    int   cycles;
    int   max_cycles;  // set once the table is built

    clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    datapath_top datapath_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_load     (pc_load),
        .pc_add      (pc_add),
        .op_mem_i    (op_mem_i),
        .add_sub     (add_sub),
        .we_reg      (we_reg),
        .we_mem      (we_mem),
        .instruction (instruction),
        .ra          (ra),
        .rb          (rb),
        .rw          (rw),
        .offset      (offset),
        .dout_a      (dout_a),
        .dout_b      (dout_b),
        .dout_mem    (dout_mem)
    );

    task automatic set_row(
        input datapath_pkg::pc_t        pc,
        input datapath_pkg::op_mem_t    op,
        input logic                     sub,
        input logic                     wr_reg,
        input logic                     wr_mem,
        input logic [31:0]              instr,
        input datapath_pkg::reg_index_t exp_ra,
        input datapath_pkg::reg_index_t exp_rb,
        input datapath_pkg::reg_index_t exp_rw,
        input datapath_pkg::data_word_t exp_off,
        input datapath_pkg::data_word_t exp_a,
        input datapath_pkg::data_word_t exp_b,
        input datapath_pkg::data_word_t exp_mem
    );
        row_t r;
        r.pc       = pc;
        r.op       = op;
        r.sub      = sub;
        r.wr_reg   = wr_reg;
        r.wr_mem   = wr_mem;
        r.instr    = datapath_pkg::instr_u'(instr);
        r.ra       = exp_ra;
        r.rb       = exp_rb;
        r.rw       = exp_rw;
        r.offset   = exp_off;
        r.dout_a   = exp_a;
        r.dout_b   = exp_b;
        r.dout_mem = exp_mem;
        rows.push_back(r);
    endtask

    // expected values worked out by hand from the program and dmem image
    task automatic build_table();
        // ld x1,1(x0), rb is the low imm bits, mem[1] = 10
        set_row(32'd0, datapath_pkg::op_mem, 1'b0, 1'b1, 1'b0,
                32'h00103083, 5'd0, 5'd1, 5'd1, 64'd1, 64'd0, 64'd0, 64'd10);
        // ld x2,2(x0)
        set_row(32'd1, datapath_pkg::op_mem, 1'b0, 1'b1, 1'b0,
                32'h00203103, 5'd0, 5'd2, 5'd2, 64'd2, 64'd0, 64'd0, 64'd20);
        // add x3,x1,x2, both loads visible now, addr 12
        set_row(32'd2, datapath_pkg::op_reg, 1'b0, 1'b1, 1'b0,
                32'h002081b3, 5'd1, 5'd2, 5'd3, 64'd2, 64'd10, 64'd20, 64'd0);
        // sub x4,x3,x1, funct7 bit gives offset 0x401, addr wraps to 15
        set_row(32'd3, datapath_pkg::op_reg, 1'b1, 1'b1, 1'b0,
                32'h40118233, 5'd3, 5'd1, 5'd4, 64'h401, 64'd30, 64'd10, 64'd0);
        // sd x3,3(x0)
        set_row(32'd4, datapath_pkg::op_mem, 1'b0, 1'b0, 1'b1,
                32'h003031a3, 5'd0, 5'd3, 5'd3, 64'd3, 64'd0, 64'd30, 64'd0);
        // same pc again, store visible
        set_row(32'd4, datapath_pkg::op_mem, 1'b0, 1'b0, 1'b0,
                32'h003031a3, 5'd0, 5'd3, 5'd3, 64'd3, 64'd0, 64'd30, 64'd30);
        // sd x4,4(x0)
        set_row(32'd5, datapath_pkg::op_mem, 1'b0, 1'b0, 1'b1,
                32'h00403223, 5'd0, 5'd4, 5'd4, 64'd4, 64'd0, 64'd20, 64'd0);
        set_row(32'd5, datapath_pkg::op_mem, 1'b0, 1'b0, 1'b0,
                32'h00403223, 5'd0, 5'd4, 5'd4, 64'd4, 64'd0, 64'd20, 64'd20);
        // addi x9,x4,10 -> 30, rb picks up imm bits (x10)
        set_row(32'd6, datapath_pkg::op_imm, 1'b0, 1'b1, 1'b0,
                32'h00a20493, 5'd4, 5'd10, 5'd9, 64'd10, 64'd20, 64'd0, 64'd0);
        // sd x9,8(x0)
        set_row(32'd7, datapath_pkg::op_mem, 1'b0, 1'b0, 1'b1,
                32'h00903423, 5'd0, 5'd9, 5'd8, 64'd8, 64'd0, 64'd30, 64'd0);
        set_row(32'd7, datapath_pkg::op_mem, 1'b0, 1'b0, 1'b0,
                32'h00903423, 5'd0, 5'd9, 5'd8, 64'd8, 64'd0, 64'd30, 64'd30);
        // ld word run as an immediate add, x1 = 0 + 1
        set_row(32'd0, datapath_pkg::op_imm, 1'b0, 1'b1, 1'b0,
                32'h00103083, 5'd0, 5'd1, 5'd1, 64'd1, 64'd0, 64'd10, 64'd10);
        // x3 = 1 - 2 wraps to all ones, addr 3 reads the stored 30
        set_row(32'd2, datapath_pkg::op_imm, 1'b1, 1'b1, 1'b0,
                32'h002081b3, 5'd1, 5'd2, 5'd3, 64'd2, 64'd1, 64'd20, 64'd30);
        // store x1 at -1 + 0x401 which wraps to word 0
        set_row(32'd3, datapath_pkg::op_reg, 1'b0, 1'b0, 1'b1,
                32'h40118233, 5'd3, 5'd1, 5'd4, 64'h401, 64'hffff_ffff_ffff_ffff,
                64'd1, 64'd0);
        // rd = 0 with we_reg high drops the load of mem[0] = 1
        set_row(32'd8, datapath_pkg::op_mem, 1'b0, 1'b1, 1'b0,
                32'h00000000, 5'd0, 5'd0, 5'd0, 64'd0, 64'd0, 64'd0, 64'd1);
        // x0 still reads zero
        set_row(32'd8, datapath_pkg::op_reg, 1'b0, 1'b0, 1'b0,
                32'h00000000, 5'd0, 5'd0, 5'd0, 64'd0, 64'd0, 64'd0, 64'd1);
        // pc 16 wraps to word 0, x1 holds the immediate result
        set_row(32'd16, datapath_pkg::op_reg, 1'b0, 1'b0, 1'b0,
                32'h00103083, 5'd0, 5'd1, 5'd1, 64'd1, 64'd0, 64'd1, 64'd10);
    endtask

    task automatic check_instr(
        input string                name,
        input datapath_pkg::instr_u got,
        input datapath_pkg::instr_u exp
    );
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            row_errs++;
        end
    endtask

    task automatic check_index(
        input string                    name,
        input datapath_pkg::reg_index_t got,
        input datapath_pkg::reg_index_t exp
    );
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            row_errs++;
        end
    endtask

    task automatic check_word(
        input string                    name,
        input datapath_pkg::data_word_t got,
        input datapath_pkg::data_word_t exp
    );
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            row_errs++;
        end
    endtask

    // one line per test, tallies pass/fail
    task automatic close_test(input string label);
        if (row_errs == 0) begin
            pass_count++;
            $display("%s ok", label);
        end else begin
            fail_count++;
            $display("%s failed with %0d mismatches", label, row_errs);
        end
    endtask

    // load cycle then execute cycle, outputs sampled mid cycle
    task automatic run_row(input int idx, input row_t r);
        @(posedge clk);
        pc_load  <= 1'b1;
        pc_add   <= r.pc;
        op_mem_i <= datapath_pkg::op_reg;
        add_sub  <= 1'b0;
        we_reg   <= 1'b0;  // no writes while pc moves
        we_mem   <= 1'b0;
        @(posedge clk);
        pc_load  <= 1'b0;
        op_mem_i <= r.op;
        add_sub  <= r.sub;
        we_reg   <= r.wr_reg;
        we_mem   <= r.wr_mem;
        @(negedge clk);
        row_errs = 0;
        check_instr("instruction", instruction, r.instr);
        check_index("ra", ra, r.ra);
        check_index("rb", rb, r.rb);
        check_index("rw", rw, r.rw);
        check_word("offset", offset, r.offset);
        check_word("dout_a", dout_a, r.dout_a);
        check_word("dout_b", dout_b, r.dout_b);
        check_word("dout_mem", dout_mem, r.dout_mem);
        close_test($sformatf("row %0d pc %0d", idx, r.pc));
    endtask

    initial begin
        pc_load    = 1'b0;
        pc_add     = '0;
        op_mem_i   = datapath_pkg::op_reg;
        add_sub    = 1'b0;
        we_reg     = 1'b0;
        we_mem     = 1'b0;
        pass_count = 0;
        fail_count = 0;
        max_cycles = 0;
        build_table();
        max_cycles = 5 + 2 * rows.size() + 20;  // reset, two per row, margin

        wait (rst_n === 1'b1);
        @(negedge clk);
        // pc at 0 after reset, dmem back to its image
        row_errs = 0;
        check_instr("instruction", instruction,
                    datapath_pkg::instr_u'(datapath_pkg::program_rom[0]));
        check_word("offset", offset, 64'd1);
        check_word("dout_mem", dout_mem, datapath_pkg::dmem_init[1]);
        close_test("reset state");

        foreach (rows[i]) begin
            run_row(i, rows[i]);
        end

        // last write lands here
        @(posedge clk);
        we_reg <= 1'b0;
        we_mem <= 1'b0;

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog on the cycle count
    initial begin
        cycles = 0;
        wait (max_cycles != 0);
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the table did not finish", max_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
common/datapath_pkg.sv
common/decode_if.sv
hw/instruction_fetch/instruction_fetch.sv
hw/register_bank.sv
hw/execute/execute_stage.sv
hw/datapath_top.sv
verif/clock_gen.sv
verif/datapath_tb.sv

// ==== Bender.yml ====
package:
  name: datapath

sources:
  - files:
      - common/datapath_pkg.sv
      - common/decode_if.sv
      - hw/instruction_fetch/instruction_fetch.sv
      - hw/register_bank.sv
      - hw/execute/execute_stage.sv
      - hw/datapath_top.sv
  - target: test
    files:
      - verif/clock_gen.sv
      - verif/datapath_tb.sv
